//--- rename_pkg.sv
// rename subsystem package: sizes, width typedefs, walker state enum, shared packed structs
package rename_pkg;

	// --------------------
	// sizes
	// --------------------
	localparam int rob_depth_c  = 32;
	localparam int rob_ptr_w_c  = 5;
	localparam int phys_regs_c  = 64;
	localparam int arch_regs_c  = 32;
	localparam int free_depth_c = 32;

	typedef logic [$clog2(arch_regs_c)-1:0]  arch_reg_t;
	typedef logic [$clog2(phys_regs_c)-1:0]  phys_tag_t;
	typedef logic [rob_ptr_w_c-1:0]          rob_idx_t;
	typedef logic [rob_ptr_w_c:0]            rob_ptr_t;   // msb is the wrap bit
	typedef logic [$clog2(free_depth_c)-1:0] fl_ptr_t;
	typedef logic [31:0]                     pc_t;

	typedef enum logic [1:0] {
		idle = 2'd0,
		walk = 2'd1
	} walk_state_t;

	// --------------------
	// interface records
	// --------------------
	typedef struct packed {
		logic      valid;
		logic      dest_valid;
		arch_reg_t logic_dest;
		arch_reg_t src_reg;
		pc_t       pc;
		logic      is_br;
		logic      br_pretaken;
	} dispatch_req_t;

	typedef struct packed {
		rob_idx_t  rob_idx;
		phys_tag_t new_tag;
		phys_tag_t old_tag;
		phys_tag_t src_tag;
	} dispatch_resp_t;

	typedef struct packed {
		logic     valid;
		rob_idx_t rob_idx;
		logic     br_taken;
	} complete_t;

	typedef struct packed {
		logic      valid;
		logic      dest_valid;
		arch_reg_t logic_dest;
		phys_tag_t new_tag;
		phys_tag_t old_tag;
		pc_t       pc;
	} retire_t;

	typedef struct packed {
		logic      valid;
		arch_reg_t logic_dest;
		phys_tag_t tag;
	} map_write_t;

endpackage

//--- free_list.sv
// free_list: ring of free physical tags with pop at the head, push at the tail, head restore
`timescale 1ns/10ps

module free_list (
	input  logic                clk,
	input  logic                rst,
	input  logic                pop_i,
	input  logic                push_i,
	input  rename_pkg::phys_tag_t push_tag_i,
	input  logic                restore_i,
	input  rename_pkg::fl_ptr_t restore_head_i,
	output rename_pkg::phys_tag_t head_tag_o,
	output rename_pkg::fl_ptr_t head_o
);

	rename_pkg::phys_tag_t ring_r [rename_pkg::free_depth_c];
	rename_pkg::fl_ptr_t   head_r;   // next tag handed out
	rename_pkg::fl_ptr_t   tail_r;   // slot for the next returned tag

	assign head_tag_o = ring_r[head_r];
	assign head_o     = head_r;

	// --------------------
	// head pointer
	// --------------------
	// a restore rewinds past every tag popped since the branch, a pop in the
	// same cycle belongs to a squashed instruction and is dropped
	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
		end else if (restore_i) begin
			head_r <= restore_head_i;
		end else if (pop_i) begin
			head_r <= head_r + 1'b1;
		end
	end

	// --------------------
	// tail and ring storage
	// --------------------
	// after reset every slot is full, so tail sits on head
	always_ff @(posedge clk) begin
		if (rst) begin
			tail_r <= '0;
			for (int i = 0; i < rename_pkg::free_depth_c; i++) begin
				ring_r[i] <= rename_pkg::phys_tag_t'(rename_pkg::arch_regs_c + i); // tags 32..63
			end
		end else if (push_i) begin
			ring_r[tail_r] <= push_tag_i;   // tail never reaches a popped slot still in flight
			tail_r         <= tail_r + 1'b1;
		end
	end

endmodule

//--- map_table.sv
// map_table: speculative logical to physical map, two read ports, rename and walk write ports
`timescale 1ns/10ps

module map_table (
	input  logic                   clk,
	input  logic                   rst,
	input  rename_pkg::arch_reg_t  dest_i,
	input  rename_pkg::arch_reg_t  src_i,
	input  rename_pkg::map_write_t rename_wr_i,
	input  rename_pkg::map_write_t walk_wr_i,
	output rename_pkg::phys_tag_t  old_tag_o,
	output rename_pkg::phys_tag_t  src_tag_o
);

	rename_pkg::phys_tag_t map_r [rename_pkg::arch_regs_c];

	// reads see the mapping before this cycle's write
	assign old_tag_o = map_r[dest_i];
	assign src_tag_o = map_r[src_i];   // source of an instruction that also writes it stays old

	// --------------------
	// write ports
	// --------------------
	// the walk port only runs while dispatch is stalled, so the two never collide
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < rename_pkg::arch_regs_c; i++) begin
				map_r[i] <= rename_pkg::phys_tag_t'(i);   // identity map
			end
		end else if (walk_wr_i.valid) begin
			map_r[walk_wr_i.logic_dest] <= walk_wr_i.tag;
		end else if (rename_wr_i.valid) begin
			map_r[rename_wr_i.logic_dest] <= rename_wr_i.tag;
		end
	end

endmodule

//--- rob.sv
// rob: reorder buffer storage, head/tail pointers, completion, in-order retire, mispredict detect
`timescale 1ns/10ps

module rob (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          alloc_i,
	input  rename_pkg::dispatch_req_t     alloc_req_i,
	input  rename_pkg::phys_tag_t         new_tag_i,
	input  rename_pkg::phys_tag_t         old_tag_i,
	input  rename_pkg::fl_ptr_t           fl_head_i,
	input  rename_pkg::complete_t         complete_i,
	input  rename_pkg::rob_idx_t          walk_idx_i,
	output rename_pkg::rob_idx_t          tail_idx_o,
	output logic                          full_o,
	output rename_pkg::retire_t           retire_o,
	output logic                          recover_o,
	output rename_pkg::rob_idx_t          recover_from_o,
	output rename_pkg::rob_idx_t          recover_to_o,
	output rename_pkg::map_write_t        walk_dest_o,
	output logic [rename_pkg::rob_depth_c-1:0] dest_mask_o,
	output rename_pkg::fl_ptr_t           snapshot_o
);

	localparam int w_c = rename_pkg::rob_ptr_w_c;

	// --------------------
	// entry storage
	// --------------------
	logic [rename_pkg::rob_depth_c-1:0] done_r;
	logic [rename_pkg::rob_depth_c-1:0] dest_r;
	logic [rename_pkg::rob_depth_c-1:0] is_br_r;
	logic [rename_pkg::rob_depth_c-1:0] pretaken_r;
	rename_pkg::arch_reg_t logic_dest_r [rename_pkg::rob_depth_c];
	rename_pkg::phys_tag_t new_tag_r    [rename_pkg::rob_depth_c];
	rename_pkg::phys_tag_t old_tag_r    [rename_pkg::rob_depth_c];
	rename_pkg::pc_t       pc_r         [rename_pkg::rob_depth_c];
	rename_pkg::fl_ptr_t   snap_r       [rename_pkg::rob_depth_c]; // free-list head after the branch

	rename_pkg::rob_ptr_t head_r;
	rename_pkg::rob_ptr_t tail_r;
	rename_pkg::rob_ptr_t br_ptr;

	rename_pkg::rob_idx_t head_idx;
	rename_pkg::rob_idx_t tail_idx;
	rename_pkg::rob_idx_t cmp_idx;
	logic                 empty;
	logic                 alloc_fire;

	assign head_idx = head_r[w_c-1:0];
	assign tail_idx = tail_r[w_c-1:0];
	assign cmp_idx  = complete_i.rob_idx;

	assign empty  = (head_r == tail_r);
	assign full_o = ((head_r ^ tail_r) == {1'b1, {w_c{1'b0}}});   // a retire does not lift it
	assign tail_idx_o = tail_idx;

	// --------------------
	// mispredict detect
	// --------------------
	assign recover_o      = complete_i.valid & is_br_r[cmp_idx] &
	                        (pretaken_r[cmp_idx] != complete_i.br_taken);
	assign recover_from_o = cmp_idx;
	assign recover_to_o   = tail_idx;   // old tail, one past the youngest squashed entry
	assign snapshot_o     = snap_r[cmp_idx];

	// an index below the tail is on the tail's lap, otherwise on the lap before
	assign br_ptr = {(cmp_idx < tail_idx) ? tail_r[w_c] : ~tail_r[w_c], cmp_idx};

	assign alloc_fire = alloc_i & ~recover_o;   // a dispatch beside a mispredict is wrong path

	// retire port, head entry
	always_comb begin
		retire_o.valid      = ~empty & done_r[head_idx];
		retire_o.dest_valid = dest_r[head_idx];
		retire_o.logic_dest = logic_dest_r[head_idx];
		retire_o.new_tag    = new_tag_r[head_idx];
		retire_o.old_tag    = old_tag_r[head_idx];
		retire_o.pc         = pc_r[head_idx];
	end

	// walk read port
	assign walk_dest_o.valid      = dest_r[walk_idx_i];
	assign walk_dest_o.logic_dest = logic_dest_r[walk_idx_i];
	assign walk_dest_o.tag        = old_tag_r[walk_idx_i];
	assign dest_mask_o            = dest_r;

	// --------------------
	// pointers and done flags
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
			done_r <= '0;
		end else begin
			if (retire_o.valid)
				head_r <= head_r + 1'b1;
			if (recover_o)
				tail_r <= br_ptr + 1'b1;   // cut back to just past the branch
			else if (alloc_fire)
				tail_r <= tail_r + 1'b1;
			if (alloc_fire)
				done_r[tail_idx] <= 1'b0;
			if (complete_i.valid)
				done_r[cmp_idx] <= 1'b1;
		end
	end

	// entry payload, written at the tail
	always_ff @(posedge clk) begin
		if (alloc_fire) begin
			dest_r[tail_idx]       <= alloc_req_i.dest_valid;
			is_br_r[tail_idx]      <= alloc_req_i.is_br;
			pretaken_r[tail_idx]   <= alloc_req_i.br_pretaken;
			logic_dest_r[tail_idx] <= alloc_req_i.logic_dest;
			new_tag_r[tail_idx]    <= new_tag_i;
			old_tag_r[tail_idx]    <= old_tag_i;
			pc_r[tail_idx]         <= alloc_req_i.pc;
			if (alloc_req_i.is_br)
				snap_r[tail_idx] <= fl_head_i + rename_pkg::fl_ptr_t'(alloc_req_i.dest_valid);
		end
	end

endmodule

//--- recovery_walker.sv
// recovery_walker: FSM that restores map entries of squashed ROB entries, youngest first
`timescale 1ns/10ps

module recovery_walker (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               start_i,
	input  rename_pkg::rob_idx_t               from_i,
	input  rename_pkg::rob_idx_t               to_i,
	input  logic [rename_pkg::rob_depth_c-1:0] dest_mask_i,
	input  rename_pkg::map_write_t             walk_dest_i,
	output rename_pkg::rob_idx_t               walk_idx_o,
	output rename_pkg::map_write_t             map_wr_o,
	output logic                               busy_o
);

	rename_pkg::walk_state_t state_r;
	rename_pkg::rob_idx_t    pos_r;    // youngest entry not yet passed
	logic [rename_pkg::rob_depth_c-1:0] pend_r;        // squashed entries still owing a write
	logic [rename_pkg::rob_depth_c-1:0] squash_mask;
	logic [rename_pkg::rob_depth_c-1:0] hit_mask;
	logic [rename_pkg::rob_depth_c-1:0] pend_left;
	rename_pkg::rob_idx_t    span;
	rename_pkg::rob_idx_t    hit_idx;

	// --------------------
	// squash range
	// --------------------
	// entries strictly between the branch and the old tail that wrote a register
	assign span = to_i - from_i - 1'b1;

	always_comb begin
		rename_pkg::rob_idx_t n;
		squash_mask = '0;
		for (int k = 1; k < rename_pkg::rob_depth_c; k++) begin
			n = from_i + rename_pkg::rob_idx_t'(k);
			if (k <= int'(span))
				squash_mask[n] = dest_mask_i[n];
		end
	end

	// nearest pending entry at or below pos, so entries without a destination cost nothing
	always_comb begin
		rename_pkg::rob_idx_t n;
		hit_idx = pos_r;
		for (int k = rename_pkg::rob_depth_c - 1; k >= 0; k--) begin
			n = pos_r - rename_pkg::rob_idx_t'(k);
			if (pend_r[n])
				hit_idx = n;   // smallest distance wins
		end
		hit_mask          = '0;
		hit_mask[hit_idx] = 1'b1;
	end

	assign pend_left = pend_r & ~hit_mask;

	// --------------------
	// state machine
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state_r <= rename_pkg::idle;
			pend_r  <= '0;
		end else begin
			case (state_r)
				rename_pkg::idle: begin
					if (start_i && (|squash_mask)) begin
						state_r <= rename_pkg::walk;
						pend_r  <= squash_mask;
						pos_r   <= to_i - 1'b1;
					end
				end
				rename_pkg::walk: begin
					pend_r <= pend_left;
					pos_r  <= hit_idx - 1'b1;
					if (!(|pend_left))
						state_r <= rename_pkg::idle;   // last write this cycle
				end
				default: state_r <= rename_pkg::idle;
			endcase
		end
	end

	assign busy_o     = (state_r == rename_pkg::walk);
	assign walk_idx_o = hit_idx;

	assign map_wr_o.valid      = busy_o & walk_dest_i.valid;
	assign map_wr_o.logic_dest = walk_dest_i.logic_dest;
	assign map_wr_o.tag        = walk_dest_i.tag;   // old tag goes back

endmodule

//--- rename_core.sv
// rename_core: top level joining free list, map table, ROB and recovery walker
`timescale 1ns/10ps

module rename_core (
	input  logic                       clk,
	input  logic                       rst,
	input  rename_pkg::dispatch_req_t  dispatch_i,
	input  rename_pkg::complete_t      complete_i,
	output rename_pkg::dispatch_resp_t dispatch_o,
	output logic                       stall_o,
	output rename_pkg::retire_t        retire_o,
	output logic                       recover_o,
	output logic                       recovery_busy_o
);

	logic                   accept;
	logic                   pop;
	logic                   push;
	logic                   rob_full;
	logic                   walk_busy;
	rename_pkg::phys_tag_t  fl_tag;
	rename_pkg::phys_tag_t  map_old;
	rename_pkg::phys_tag_t  map_src;
	rename_pkg::fl_ptr_t    fl_head;
	rename_pkg::fl_ptr_t    snapshot;
	rename_pkg::rob_idx_t   tail_idx;
	rename_pkg::rob_idx_t   rec_from;
	rename_pkg::rob_idx_t   rec_to;
	rename_pkg::rob_idx_t   walk_idx;
	rename_pkg::map_write_t rename_wr;
	rename_pkg::map_write_t walk_wr;
	rename_pkg::map_write_t walk_dest;
	logic [rename_pkg::rob_depth_c-1:0] dest_mask;

	assign stall_o         = rob_full | walk_busy;
	assign recovery_busy_o = walk_busy;

	assign accept = dispatch_i.valid & ~stall_o;
	assign pop    = accept & dispatch_i.dest_valid;
	assign push   = retire_o.valid & retire_o.dest_valid;   // old tag is free again

	// --------------------
	// rename result
	// --------------------
	assign dispatch_o.rob_idx = tail_idx;
	assign dispatch_o.new_tag = dispatch_i.dest_valid ? fl_tag : '0;
	assign dispatch_o.old_tag = dispatch_i.dest_valid ? map_old : '0;
	assign dispatch_o.src_tag = map_src;

	assign rename_wr.valid      = pop & ~recover_o;   // wrong-path dispatch leaves the map alone
	assign rename_wr.logic_dest = dispatch_i.logic_dest;
	assign rename_wr.tag        = fl_tag;

	free_list u_free_list (
		.clk            (clk),
		.rst            (rst),
		.pop_i          (pop),
		.push_i         (push),
		.push_tag_i     (retire_o.old_tag),
		.restore_i      (recover_o),
		.restore_head_i (snapshot),
		.head_tag_o     (fl_tag),
		.head_o         (fl_head)
	);

	map_table u_map_table (
		.clk         (clk),
		.rst         (rst),
		.dest_i      (dispatch_i.logic_dest),
		.src_i       (dispatch_i.src_reg),
		.rename_wr_i (rename_wr),
		.walk_wr_i   (walk_wr),
		.old_tag_o   (map_old),
		.src_tag_o   (map_src)
	);

	rob u_rob (
		.clk            (clk),
		.rst            (rst),
		.alloc_i        (accept),
		.alloc_req_i    (dispatch_i),
		.new_tag_i      (dispatch_o.new_tag),
		.old_tag_i      (dispatch_o.old_tag),
		.fl_head_i      (fl_head),
		.complete_i     (complete_i),
		.walk_idx_i     (walk_idx),
		.tail_idx_o     (tail_idx),
		.full_o         (rob_full),
		.retire_o       (retire_o),
		.recover_o      (recover_o),
		.recover_from_o (rec_from),
		.recover_to_o   (rec_to),
		.walk_dest_o    (walk_dest),
		.dest_mask_o    (dest_mask),
		.snapshot_o     (snapshot)
	);

	recovery_walker u_recovery_walker (
		.clk         (clk),
		.rst         (rst),
		.start_i     (recover_o),
		.from_i      (rec_from),
		.to_i        (rec_to),
		.dest_mask_i (dest_mask),
		.walk_dest_i (walk_dest),
		.walk_idx_o  (walk_idx),
		.map_wr_o    (walk_wr),
		.busy_o      (walk_busy)
	);

endmodule

//--- rename_core_asserts.sv
// rename_core_asserts: bound protocol checks on dispatch hold, completion and recovery timing
`timescale 1ns/10ps

module rename_core_asserts (
	input logic                      clk,
	input logic                      rst,
	input rename_pkg::dispatch_req_t dispatch_i,
	input rename_pkg::complete_t     complete_i,
	input logic                      stall_o,
	input logic                      recover_o,
	input logic                      recovery_busy_o
);

	// --------------------
	// environment rules
	// --------------------
	// a stalled request stays on the bus until it is taken
	hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
		(dispatch_i.valid && stall_o) |=> $stable(dispatch_i))
		else $error("dispatch request changed while stalled");

	no_complete_in_walk: assert property (@(posedge clk) disable iff (rst)
		complete_i.valid |-> !recovery_busy_o)
		else $error("completion arrived during a recovery walk");

	// nested recovery is not supported
	no_recover_in_walk: assert property (@(posedge clk) disable iff (rst)
		recover_o |-> !recovery_busy_o)
		else $error("mispredict raised during a recovery walk");

endmodule

//--- rename_core_tb.sv
// rename_core_tb: clock, reset, LFSR stimulus, reference model of free list, map and ROB, checks
`timescale 1ns/10ps

module rename_core_tb;

	localparam int planned_cycles_c = 3200;
	localparam int timeout_cycles_c = 4 * planned_cycles_c;

	// one in-flight instruction as the model sees it
	typedef struct packed {
		rename_pkg::rob_idx_t  idx;
		logic                  dest_valid;
		rename_pkg::arch_reg_t logic_dest;
		rename_pkg::phys_tag_t new_tag;
		rename_pkg::phys_tag_t old_tag;
		rename_pkg::pc_t       pc;
		logic                  is_br;
		logic                  pretaken;
		logic                  done;
	} entry_t;

	logic                       clk;
	logic                       rst;
	rename_pkg::dispatch_req_t  dispatch_i;
	rename_pkg::complete_t      complete_i;
	rename_pkg::dispatch_resp_t dispatch_o;
	logic                       stall_o;
	rename_pkg::retire_t        retire_o;
	logic                       recover_o;
	logic                       recovery_busy_o;

	entry_t                rob_q [$];    // oldest at index 0
	rename_pkg::phys_tag_t free_q [$];   // next tag handed out at index 0
	rename_pkg::phys_tag_t map_m [rename_pkg::arch_regs_c];
	rename_pkg::rob_idx_t  tail_m;
	int                    busy_left;    // walk cycles still owed
	bit                    held;         // request on the bus was not taken
	bit                    branches_on;
	logic [31:0]           lfsr;
	int                    cycle_count;
	int                    recoveries;
	int                    good_branches;

	rename_core u_rename_core (
		.clk             (clk),
		.rst             (rst),
		.dispatch_i      (dispatch_i),
		.complete_i      (complete_i),
		.dispatch_o      (dispatch_o),
		.stall_o         (stall_o),
		.retire_o        (retire_o),
		.recover_o       (recover_o),
		.recovery_busy_o (recovery_busy_o)
	);

	bind rename_core rename_core_asserts u_rename_core_asserts (.*);

	// --------------------
	// helpers
	// --------------------
	// galois LFSR, one step per bit taken
	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			if (lfsr[0])
				lfsr = (lfsr >> 1) ^ 32'h8020_0003;
			else
				lfsr = lfsr >> 1;
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	task automatic check_val(input string what, input int got, input int exp);
		assert (got == exp) else begin
			$display("MISMATCH %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			$display("Test failed");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic abort_run(input string why);
		$display("ERROR %0t ns: %s", $time, why);
		$display("Test failed");
		$fatal(1, "run aborted");
	endtask

	task automatic reset_model();
		rob_q.delete();
		free_q.delete();
		for (int i = 0; i < rename_pkg::free_depth_c; i++)
			free_q.push_back(rename_pkg::phys_tag_t'(rename_pkg::arch_regs_c + i)); // tags 32..63
		for (int i = 0; i < rename_pkg::arch_regs_c; i++)
			map_m[i] = rename_pkg::phys_tag_t'(i);
		tail_m        = '0;
		busy_left     = 0;
		held          = 1'b0;
		recoveries    = 0;
		good_branches = 0;
	endtask

	// --------------------
	// one clock cycle
	// --------------------
	// comp_level 0..3 sets the completion rate, 4 completes the oldest open entry every cycle
	task automatic step_cycle(input int comp_level, input bit new_ok, input bit always_disp);
		rename_pkg::dispatch_req_t req;
		rename_pkg::complete_t     cmp;
		entry_t                    e;
		int                        pick;
		int                        pos;
		int                        n;
		bit                        stall_exp;
		bit                        misp;
		bit                        acc;
		bit                        ret;

		@(posedge clk);
		#10;
		stall_exp = (rob_q.size() == rename_pkg::rob_depth_c) || (busy_left > 0);
		req = dispatch_i;
		if (!held) begin
			req = '0;
			if (new_ok && (always_disp || rand_bits(3) != 0)) begin
				req.valid       = 1'b1;
				req.dest_valid  = (rand_bits(3) != 0);
				req.logic_dest  = rename_pkg::arch_reg_t'(rand_bits(5));
				req.src_reg     = rename_pkg::arch_reg_t'(rand_bits(5));
				req.pc          = rename_pkg::pc_t'(rand_bits(16) << 2);
				req.is_br       = branches_on && (rand_bits(2) == 0);
				req.br_pretaken = (rand_bits(1) != 0);
			end
		end

		cmp  = '0;
		pos  = -1;
		misp = 1'b0;
		if (busy_left == 0 && rob_q.size() > 0 && rand_bits(2) < comp_level) begin
			pick = (comp_level >= 4) ? 0 : rand_bits(5) % rob_q.size();
			for (int i = 0; i < rob_q.size(); i++) begin
				if (pos < 0 && !rob_q[(pick + i) % rob_q.size()].done)
					pos = (pick + i) % rob_q.size();
			end
		end
		if (pos >= 0) begin
			cmp.valid    = 1'b1;
			cmp.rob_idx  = rob_q[pos].idx;
			cmp.br_taken = rob_q[pos].pretaken ^ (rand_bits(2) == 0);  // one in four wrong
			misp = rob_q[pos].is_br && (rob_q[pos].pretaken != cmp.br_taken);
			if (misp && req.valid && !stall_exp) begin
				cmp  = '0;   // a redirect beside a taken dispatch would drop it
				pos  = -1;
				misp = 1'b0;
			end
		end
		dispatch_i = req;
		complete_i = cmp;

		// outputs are settled by the falling edge
		@(negedge clk);
		ret = (rob_q.size() > 0) && rob_q[0].done;
		acc = req.valid && !stall_exp;
		check_val("stall_o", int'(stall_o), int'(stall_exp));
		check_val("recovery_busy_o", int'(recovery_busy_o), int'(busy_left > 0));
		check_val("recover_o", int'(recover_o), int'(misp));
		check_val("retire valid", int'(retire_o.valid), int'(ret));
		if (ret) begin
			e = rob_q[0];
			check_val("retire dest_valid", int'(retire_o.dest_valid), int'(e.dest_valid));
			check_val("retire logic_dest", int'(retire_o.logic_dest), int'(e.logic_dest));
			check_val("retire new_tag", int'(retire_o.new_tag), int'(e.new_tag));
			check_val("retire old_tag", int'(retire_o.old_tag), int'(e.old_tag));
			check_val("retire pc", int'(retire_o.pc), int'(e.pc));
		end
		if (acc) begin
			check_val("rob_idx", int'(dispatch_o.rob_idx), int'(tail_m));
			check_val("new_tag", int'(dispatch_o.new_tag),
				req.dest_valid ? int'(free_q[0]) : 0);
			check_val("old_tag", int'(dispatch_o.old_tag),
				req.dest_valid ? int'(map_m[req.logic_dest]) : 0);
			check_val("src_tag", int'(dispatch_o.src_tag), int'(map_m[req.src_reg]));
		end
		held = req.valid && !acc;

		// model state after the coming edge
		if (busy_left > 0)
			busy_left--;
		if (pos >= 0) begin
			e          = rob_q[pos];
			e.done     = 1'b1;
			rob_q[pos] = e;
			if (misp) begin
				n = 0;
				// youngest first, so the oldest squashed writer of a register sets it last
				for (int i = rob_q.size() - 1; i > pos; i--) begin
					if (rob_q[i].dest_valid) begin
						map_m[rob_q[i].logic_dest] = rob_q[i].old_tag;
						free_q.push_front(rob_q[i].new_tag);
						n++;
					end
				end
				while (rob_q.size() > pos + 1)
					rob_q.delete(rob_q.size() - 1);
				tail_m    = e.idx + rename_pkg::rob_idx_t'(1);
				busy_left = n;
				recoveries++;
			end else if (e.is_br) begin
				good_branches++;
			end
		end
		if (ret) begin
			e = rob_q.pop_front();
			if (e.dest_valid)
				free_q.push_back(e.old_tag);   // previous mapping is free again
		end
		if (acc) begin
			e.idx        = tail_m;
			e.dest_valid = req.dest_valid;
			e.logic_dest = req.logic_dest;
			e.new_tag    = '0;
			e.old_tag    = '0;
			e.pc         = req.pc;
			e.is_br      = req.is_br;
			e.pretaken   = req.br_pretaken;
			e.done       = 1'b0;
			if (req.dest_valid) begin
				e.old_tag               = map_m[req.logic_dest];
				e.new_tag               = free_q.pop_front();
				map_m[req.logic_dest] = e.new_tag;
			end
			rob_q.push_back(e);
			tail_m++;
		end
	endtask

	// --------------------
	// clock and timeout
	// --------------------
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles_c)
			abort_run("timeout, the run did not finish within the cycle limit");
	end

	// --------------------
	// test sequence
	// --------------------
	initial begin
		lfsr        = 32'd75977;
		cycle_count = 0;
		branches_on = 1'b0;
		rst         = 1'b1;
		dispatch_i  = '0;
		complete_i  = '0;
		reset_model();
		repeat (4) @(posedge clk);
		#10;
		rst = 1'b0;
		@(negedge clk);
		check_val("retire valid after reset", int'(retire_o.valid), 0);
		check_val("stall_o after reset", int'(stall_o), 0);
		check_val("recover_o after reset", int'(recover_o), 0);
		check_val("recovery_busy_o after reset", int'(recovery_busy_o), 0);

		// fill the ROB with no completions and no branches
		repeat (48) step_cycle(0, 1'b1, 1'b1);
		check_val("stall_o when full", int'(stall_o), 1);
		step_cycle(4, 1'b1, 1'b1);   // complete the head
		step_cycle(0, 1'b1, 1'b1);   // head retires
		check_val("retire valid when full", int'(retire_o.valid), 1);
		check_val("stall_o while the head retires", int'(stall_o), 1);
		step_cycle(0, 1'b1, 1'b1);   // held request goes in
		check_val("stall_o after one retire", int'(stall_o), 0);
		check_val("held dispatch valid after one retire", int'(dispatch_i.valid), 1);

		// mixed traffic with branches, completion rate stepping up and down
		branches_on = 1'b1;
		for (int p = 0; p < 12; p++)
			repeat (250) step_cycle(p % 3 + 1, 1'b1, 1'b0);

		// drain everything that is left
		while (rob_q.size() != 0 || busy_left != 0 || held)
			step_cycle(4, 1'b0, 1'b0);

		if (recoveries > 0 && good_branches > 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			abort_run("traffic gave no mispredict or no correctly predicted branch");
		end
	end

endmodule

//--- filelist.f
rename_pkg.sv
free_list.sv
map_table.sv
rob.sv
recovery_walker.sv
rename_core.sv
rename_core_asserts.sv
rename_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= rename_core_tb
DUT_TOP   ?= rename_core
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?=
LINTFLAGS ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -j $(JOBS) $(VFLAGS) \
		-f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP)

lint:
	$(VERILATOR) --lint-only --timing $(LINTFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(BUILD_DIR)
